//--- Makefile
SIM      := verilator
VFLAGS   := --binary --timing --assert -Wno-fatal
TOP      := axi_mem_tb
FILELIST := project.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

SOURCES  := $(wildcard design/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/axi_mem_tb_model.svh
// Reference model for the AXI memory testbench: shadow bytes, write merge, expected read and response
`ifndef AXI_MEM_TB_MODEL_SVH
`define AXI_MEM_TB_MODEL_SVH

logic [7:0] shadow_mem [0:MEM_BYTES-1];

function automatic logic addr_in_range(input logic [31:0] addr);
  return addr < 32'(MEM_BYTES);
endfunction

// Out-of-range writes leave the shadow untouched
function automatic void apply_write(input logic [31:0] addr, input logic [63:0] data,
                                    input logic [7:0] strb);
  int base;
  base = int'({addr[31:3], 3'b000});
  if (addr_in_range(addr)) begin
    for (int lane = 0; lane < 8; lane++) begin
      if (strb[lane]) shadow_mem[base + lane] = data[lane*8 +: 8];
    end
  end
endfunction

function automatic logic [63:0] expected_read(input logic [31:0] addr);
  logic [63:0] word;
  int          base;
  word = '0;
  base = int'({addr[31:3], 3'b000});
  if (addr_in_range(addr)) begin
    for (int lane = 0; lane < 8; lane++) word[lane*8 +: 8] = shadow_mem[base + lane];
  end
  return word;
endfunction

function automatic logic [1:0] expected_resp(input logic [31:0] addr);
  return addr_in_range(addr) ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
endfunction

`endif

//--- bench/axi_mem_tb.sv
// Testbench with clock, reset, channel drivers, checks and watchdog for the AXI4 SRAM subsystem
`timescale 1ns/10ps

module axi_mem_tb;

  localparam int MEM_BYTES  = 4096;
  localparam int WORDS      = MEM_BYTES / 8;
  localparam int RST_CYCLES = 8;
  localparam int N_BASIC    = 64;
  localparam int N_PART     = 32;
  localparam int N_OOR      = 8;
  localparam int N_JOBS     = 32;
  // Stall and concurrent tests each run one batch of jobs
  localparam int NUM_TXNS   = 2*N_BASIC + 2*N_PART + 3*N_OOR + 4*N_JOBS;

  logic                 aclk = 1'b0;
  logic                 rst;
  axi_mem_pkg::axi_aw_t aw;
  logic                 aw_valid;
  logic                 aw_ready;
  axi_mem_pkg::axi_w_t  w;
  logic                 w_valid;
  logic                 w_ready;
  axi_mem_pkg::axi_b_t  b;
  logic                 b_valid;
  logic                 b_ready = 1'b1;
  axi_mem_pkg::axi_ar_t ar;
  logic                 ar_valid;
  logic                 ar_ready;
  axi_mem_pkg::axi_r_t  r;
  logic                 r_valid;
  logic                 r_ready = 1'b1;

  int seed = 38;
  logic stall_en = 1'b0;
  int r_hold = 0;
  int b_hold = 0;
  int r_issued = 0;
  int r_seen = 0;
  int b_issued = 0;
  int b_seen = 0;
  logic r_stalled = 1'b0;
  logic b_stalled = 1'b0;
  axi_mem_pkg::axi_r_t last_r;
  axi_mem_pkg::axi_b_t last_b;
  axi_mem_pkg::axi_r_t exp_r_item;
  axi_mem_pkg::axi_b_t exp_b_item;
  axi_mem_pkg::axi_r_t exp_r_q[$];
  axi_mem_pkg::axi_b_t exp_b_q[$];

  int          basic_idx [N_BASIC];
  int          job_widx [N_JOBS];
  int          job_ridx [N_JOBS];
  logic [3:0]  job_id [N_JOBS];
  logic [63:0] job_data [N_JOBS];
  logic [7:0]  job_strb [N_JOBS];
  logic [31:0] addr_v;
  logic [63:0] data_v;
  logic [3:0]  id_v;
  logic [7:0]  strb_v;

  `include "axi_mem_tb_model.svh"

  always #2 aclk = ~aclk;

  axi_mem_top #(.MEM_BYTES(MEM_BYTES)) u_dut (
    .i_aclk (aclk), .i_rst (rst),
    .i_aw (aw), .i_aw_valid (aw_valid), .o_aw_ready (aw_ready),
    .i_w (w), .i_w_valid (w_valid), .o_w_ready (w_ready),
    .o_b (b), .o_b_valid (b_valid), .i_b_ready (b_ready),
    .i_ar (ar), .i_ar_valid (ar_valid), .o_ar_ready (ar_ready),
    .o_r (r), .o_r_valid (r_valid), .i_r_ready (r_ready)
  );

  // --------------------------------------------------------------------------
  // Helpers

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = rand32();
    return {hi, rand32()};
  endfunction

  // Cycles a ready line stays at its new level
  function automatic int stretch(input logic level);
    return level ? 1 + int'(rand32() % 32'd3) : 1 + int'(rand32() % 32'd8);
  endfunction

  // Upper jobs write the top half of memory away from every word read back
  function automatic void make_jobs(input logic upper);
    for (int k = 0; k < N_JOBS; k++) begin
      job_widx[k] = upper ? WORDS / 2 + int'(rand32() % 32'(WORDS / 2))
                          : basic_idx[int'(rand32() % 32'(N_BASIC))];
      job_ridx[k] = basic_idx[int'(rand32() % 32'(N_BASIC))];
      job_id[k]   = 4'(rand32());
      job_data[k] = rand64();
      job_strb[k] = 8'(rand32());
    end
  endfunction

  task automatic end_with_failure();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // Returns just after the edge that took the transfer
  task automatic wait_accept(input int chan);
    logic seen;
    do begin
      @(negedge aclk);
      seen = (chan == 0) ? aw_ready : (chan == 1) ? w_ready : ar_ready;
      @(posedge aclk);
    end while (!seen);
    #1;
  endtask

  task automatic write_word(input logic [3:0] id, input logic [31:0] addr,
                            input logic [63:0] data, input logic [7:0] strb);
    int target;
    exp_b_q.push_back(axi_mem_pkg::axi_b_t'{id: id, resp: expected_resp(addr)});
    apply_write(addr, data, strb);
    b_issued++;
    target = b_issued;
    @(posedge aclk);
    #1;
    aw = '0;
    aw.id = id;
    aw.addr = addr;
    aw.size = 3'd3;
    aw.burst = 2'b01;
    aw_valid = 1'b1;
    wait_accept(0);
    aw_valid = 1'b0;
    w.data = data;
    w.strb = strb;
    w.last = 1'b1;
    w_valid = 1'b1;
    wait_accept(1);
    w_valid = 1'b0;
    while (b_seen < target) @(posedge aclk);
  endtask

  task automatic read_word(input logic [3:0] id, input logic [31:0] addr);
    int target;
    exp_r_q.push_back(axi_mem_pkg::axi_r_t'{id: id, data: expected_read(addr),
                                            resp: expected_resp(addr), last: 1'b1});
    r_issued++;
    target = r_issued;
    @(posedge aclk);
    #1;
    ar = '0;
    ar.id = id;
    ar.addr = addr;
    ar.size = 3'd3;
    ar.burst = 2'b01;
    ar_valid = 1'b1;
    wait_accept(2);
    ar_valid = 1'b0;
    while (r_seen < target) @(posedge aclk);
  endtask

  // --------------------------------------------------------------------------
  // Response back-pressure

  always @(posedge aclk) begin
    #1;
    if (!stall_en) begin
      r_ready = 1'b1;
      b_ready = 1'b1;
    end else begin
      if (r_hold == 0) begin
        r_ready = !r_ready;
        r_hold = stretch(r_ready);
      end
      if (b_hold == 0) begin
        b_ready = !b_ready;
        b_hold = stretch(b_ready);
      end
      r_hold--;
      b_hold--;
    end
  end

  // --------------------------------------------------------------------------
  // Compare process sampled mid-cycle where valid and ready are settled

  always @(negedge aclk) begin
    if (!rst) begin
      if (r_stalled) begin
        check_value("o_r_valid", 1, r_valid);
        check_value("o_r", last_r, r);
      end
      if (b_stalled) begin
        check_value("o_b_valid", 1, b_valid);
        check_value("o_b", last_b, b);
      end
      if (r_valid && r_ready) begin
        if (exp_r_q.size() == 0) begin
          $display("R response at %0d ns with no read outstanding", $time);
          end_with_failure();
        end else begin
          exp_r_item = exp_r_q.pop_front();
          check_value("o_r.id", exp_r_item.id, r.id);
          check_value("o_r.data", exp_r_item.data, r.data);
          check_value("o_r.resp", exp_r_item.resp, r.resp);
          check_value("o_r.last", exp_r_item.last, r.last);
          r_seen++;
        end
      end
      if (b_valid && b_ready) begin
        if (exp_b_q.size() == 0) begin
          $display("B response at %0d ns with no write outstanding", $time);
          end_with_failure();
        end else begin
          exp_b_item = exp_b_q.pop_front();
          check_value("o_b.id", exp_b_item.id, b.id);
          check_value("o_b.resp", exp_b_item.resp, b.resp);
          b_seen++;
        end
      end
      r_stalled = r_valid && !r_ready;
      b_stalled = b_valid && !b_ready;
      last_r = r;
      last_b = b;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence

  initial begin
    rst = 1'b1;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk);
    #1;
    rst = 1'b0;
    @(negedge aclk);
    check_value("o_aw_ready", 1, aw_ready);
    check_value("o_ar_ready", 1, ar_ready);
    check_value("o_r_valid", 0, r_valid);
    check_value("o_b_valid", 0, b_valid);
    check_value("o_w_ready", 0, w_ready);

    // Full-strobe writes to the lower half with a read back of each
    for (int k = 0; k < N_BASIC; k++) begin
      basic_idx[k] = int'(rand32() % 32'(WORDS / 2));
      id_v = 4'(rand32());
      data_v = rand64();
      write_word(id_v, 32'(basic_idx[k] * 8), data_v, 8'hff);
      read_word(4'(rand32()), 32'(basic_idx[k] * 8));
    end

    // Partial strobes over words already written
    for (int k = 0; k < N_PART; k++) begin
      addr_v = 32'(basic_idx[int'(rand32() % 32'(N_BASIC))] * 8);
      id_v = 4'(rand32());
      data_v = rand64();
      strb_v = 8'(rand32());
      write_word(id_v, addr_v, data_v, strb_v);
      read_word(4'(rand32()), addr_v);
    end

    // Out-of-range accesses followed by a read of the aliased word
    for (int k = 0; k < N_OOR; k++) begin
      addr_v = 32'(basic_idx[k] * 8);
      id_v = 4'(rand32());
      data_v = rand64();
      write_word(id_v, addr_v + 32'(MEM_BYTES * (k + 1)), data_v, 8'hff);
      read_word(4'(rand32()), addr_v + 32'(MEM_BYTES * (k + 1)));
      read_word(4'(rand32()), addr_v);
    end

    make_jobs(1'b0);
    stall_en = 1'b1;
    for (int k = 0; k < N_JOBS; k++) begin
      write_word(job_id[k], 32'(job_widx[k] * 8), job_data[k], job_strb[k]);
      read_word(job_id[k], 32'(job_widx[k] * 8));
    end
    stall_en = 1'b0;

    // Concurrent traffic on disjoint words
    make_jobs(1'b1);
    fork
      for (int k = 0; k < N_JOBS; k++) begin
        write_word(job_id[k], 32'(job_widx[k] * 8), job_data[k], job_strb[k]);
      end
      for (int k = 0; k < N_JOBS; k++) begin
        read_word(job_id[k], 32'(job_ridx[k] * 8));
      end
    join

    // No response may remain once every request is answered
    @(negedge aclk);
    check_value("o_r_valid", 0, r_valid);
    check_value("o_b_valid", 0, b_valid);
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    repeat (NUM_TXNS * 40) @(posedge aclk);
    $display("Timed out after %0d cycles with transfers still pending", NUM_TXNS * 40);
    end_with_failure();
  end

endmodule

//--- design/axi_mem_pkg.sv
// AXI4 memory bus widths, response codes and channel payload structs
package axi_mem_pkg;

  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // --------------------------------------------------------------------------
  // Address channels

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [1:0]            lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
  } axi_aw_t;

  // Same layout as AW
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [1:0]            lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
  } axi_ar_t;

  // --------------------------------------------------------------------------
  // Data and response channels

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

endpackage

//--- design/axi_mem_top.sv
// AXI4 memory subsystem top joining the slave front end to the SRAM
`timescale 1ns/10ps

module axi_mem_top #(
  parameter  int MEM_BYTES = 4096,
  localparam int WORDS     = MEM_BYTES / axi_mem_pkg::AXI_STRB_W,
  localparam int IDX_W     = $clog2(WORDS)
) (
  input  logic                 i_aclk,
  input  logic                 i_rst,

  // Write address
  input  axi_mem_pkg::axi_aw_t i_aw,
  input  logic                 i_aw_valid,
  output logic                 o_aw_ready,

  // Write data
  input  axi_mem_pkg::axi_w_t  i_w,
  input  logic                 i_w_valid,
  output logic                 o_w_ready,

  // Write response
  output axi_mem_pkg::axi_b_t  o_b,
  output logic                 o_b_valid,
  input  logic                 i_b_ready,

  // Read address
  input  axi_mem_pkg::axi_ar_t i_ar,
  input  logic                 i_ar_valid,
  output logic                 o_ar_ready,

  // Read data
  output axi_mem_pkg::axi_r_t  o_r,
  output logic                 o_r_valid,
  input  logic                 i_r_ready
);

  // --------------------------------------------------------------------------
  // Slave to SRAM

  logic                               wr_en;
  logic [IDX_W-1:0]                   wr_idx;
  logic [axi_mem_pkg::AXI_DATA_W-1:0] wr_data;
  logic [axi_mem_pkg::AXI_STRB_W-1:0] wr_strb;
  logic                               rd_en;
  logic [IDX_W-1:0]                   rd_idx;
  logic [axi_mem_pkg::AXI_DATA_W-1:0] rd_data;

  axi_sram_slave #(
    .MEM_BYTES (MEM_BYTES)
  ) u_slave (
    .i_aclk     (i_aclk),
    .i_rst      (i_rst),
    .i_aw       (i_aw),
    .i_aw_valid (i_aw_valid),
    .o_aw_ready (o_aw_ready),
    .i_w        (i_w),
    .i_w_valid  (i_w_valid),
    .o_w_ready  (o_w_ready),
    .o_b        (o_b),
    .o_b_valid  (o_b_valid),
    .i_b_ready  (i_b_ready),
    .i_ar       (i_ar),
    .i_ar_valid (i_ar_valid),
    .o_ar_ready (o_ar_ready),
    .o_r        (o_r),
    .o_r_valid  (o_r_valid),
    .i_r_ready  (i_r_ready),
    .o_wr_en    (wr_en),
    .o_wr_idx   (wr_idx),
    .o_wr_data  (wr_data),
    .o_wr_strb  (wr_strb),
    .o_rd_en    (rd_en),
    .o_rd_idx   (rd_idx),
    .i_rd_data  (rd_data)
  );

  sram_array #(
    .MEM_BYTES (MEM_BYTES)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_wr_en   (wr_en),
    .i_wr_idx  (wr_idx),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .i_rd_en   (rd_en),
    .i_rd_idx  (rd_idx),
    .o_rd_data (rd_data)
  );

endmodule

//--- design/axi_sram_slave.sv
// AXI4 single-beat slave with read and write FSMs, range decode and B/R generation
`timescale 1ns/10ps

module axi_sram_slave #(
  parameter  int MEM_BYTES = 4096,
  localparam int WORDS     = MEM_BYTES / axi_mem_pkg::AXI_STRB_W,
  localparam int IDX_W     = $clog2(WORDS)
) (
  input  logic                               i_aclk,
  input  logic                               i_rst,

  // Write address
  input  axi_mem_pkg::axi_aw_t               i_aw,
  input  logic                               i_aw_valid,
  output logic                               o_aw_ready,

  // Write data
  input  axi_mem_pkg::axi_w_t                i_w,
  input  logic                               i_w_valid,
  output logic                               o_w_ready,

  // Write response
  output axi_mem_pkg::axi_b_t                o_b,
  output logic                               o_b_valid,
  input  logic                               i_b_ready,

  // Read address
  input  axi_mem_pkg::axi_ar_t               i_ar,
  input  logic                               i_ar_valid,
  output logic                               o_ar_ready,

  // Read data
  output axi_mem_pkg::axi_r_t                o_r,
  output logic                               o_r_valid,
  input  logic                               i_r_ready,

  // SRAM side
  output logic                               o_wr_en,
  output logic [IDX_W-1:0]                   o_wr_idx,
  output logic [axi_mem_pkg::AXI_DATA_W-1:0] o_wr_data,
  output logic [axi_mem_pkg::AXI_STRB_W-1:0] o_wr_strb,
  output logic                               o_rd_en,
  output logic [IDX_W-1:0]                   o_rd_idx,
  input  logic [axi_mem_pkg::AXI_DATA_W-1:0] i_rd_data
);

  // Byte offset bits below the word index
  localparam int OFS_W = $clog2(axi_mem_pkg::AXI_STRB_W);
  localparam logic [axi_mem_pkg::AXI_ADDR_W-1:0] MEM_LIMIT =
    axi_mem_pkg::AXI_ADDR_W'(MEM_BYTES);

  typedef enum logic [0:0] {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  rd_state_t rd_state;
  wr_state_t wr_state;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  logic aw_hit;
  logic ar_hit;

  logic [axi_mem_pkg::AXI_ID_W-1:0] rd_id;
  logic                             rd_hit;
  logic [axi_mem_pkg::AXI_ID_W-1:0] wr_id;
  logic [IDX_W-1:0]                 wr_idx;
  logic                             wr_hit;
  logic [1:0]                       b_resp;

  assign aw_fire = i_aw_valid & o_aw_ready;
  assign w_fire  = i_w_valid  & o_w_ready;
  assign b_fire  = o_b_valid  & i_b_ready;
  assign ar_fire = i_ar_valid & o_ar_ready;
  assign r_fire  = o_r_valid  & i_r_ready;

  assign aw_hit = (i_aw.addr < MEM_LIMIT);
  assign ar_hit = (i_ar.addr < MEM_LIMIT);

  // --------------------------------------------------------------------------
  // Read channel

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_RESP;
        RD_RESP: if (r_fire) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_id  <= i_ar.id;
      rd_hit <= ar_hit;
    end
  end

  // SRAM output holds until the next AR, so R stays stable under stall
  assign o_rd_en  = ar_fire & ar_hit;
  assign o_rd_idx = i_ar.addr[OFS_W +: IDX_W];

  assign o_ar_ready = (rd_state == RD_IDLE);
  assign o_r_valid  = (rd_state == RD_RESP);

  always_comb begin
    o_r.id   = rd_id;
    o_r.data = rd_hit ? i_rd_data : '0;
    o_r.resp = rd_hit ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
    o_r.last = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Write channel

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (aw_fire) wr_state <= WR_DATA;
        WR_DATA: if (w_fire) wr_state <= WR_RESP;
        WR_RESP: if (b_fire) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_id  <= i_aw.id;
      wr_idx <= i_aw.addr[OFS_W +: IDX_W];
      wr_hit <= aw_hit;
    end
    if (w_fire) begin
      b_resp <= wr_hit ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
    end
  end

  // Misses leave memory untouched
  assign o_wr_en   = w_fire & wr_hit;
  assign o_wr_idx  = wr_idx;
  assign o_wr_data = i_w.data;
  assign o_wr_strb = i_w.strb;

  assign o_aw_ready = (wr_state == WR_IDLE);
  assign o_w_ready  = (wr_state == WR_DATA);
  assign o_b_valid  = (wr_state == WR_RESP);

  assign o_b.id   = wr_id;
  assign o_b.resp = b_resp;

  // --------------------------------------------------------------------------
  // Protocol checks

  // Single-beat only
  a_aw_len_zero : assert property (
    @(posedge i_aclk) disable iff (i_rst) i_aw_valid |-> (i_aw.len == 8'd0)
  ) else $error("axi_sram_slave: AW burst length %0d", i_aw.len);

  a_ar_len_zero : assert property (
    @(posedge i_aclk) disable iff (i_rst) i_ar_valid |-> (i_ar.len == 8'd0)
  ) else $error("axi_sram_slave: AR burst length %0d", i_ar.len);

  a_w_last : assert property (
    @(posedge i_aclk) disable iff (i_rst) i_w_valid |-> i_w.last
  ) else $error("axi_sram_slave: W beat without last");

  a_r_stable : assert property (
    @(posedge i_aclk) disable iff (i_rst)
      (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r))
  ) else $error("axi_sram_slave: R changed while stalled");

  a_b_stable : assert property (
    @(posedge i_aclk) disable iff (i_rst)
      (o_b_valid && !i_b_ready) |=> (o_b_valid && $stable(o_b))
  ) else $error("axi_sram_slave: B changed while stalled");

endmodule

//--- design/sram_array.sv
// Single-clock SRAM with one byte-strobed write port and one registered read port
`timescale 1ns/10ps

module sram_array #(
  parameter  int MEM_BYTES = 4096,
  localparam int WORDS     = MEM_BYTES / axi_mem_pkg::AXI_STRB_W,
  localparam int IDX_W     = $clog2(WORDS)
) (
  input  logic                              i_aclk,

  // Write port
  input  logic                              i_wr_en,
  input  logic [IDX_W-1:0]                  i_wr_idx,
  input  logic [axi_mem_pkg::AXI_DATA_W-1:0] i_wr_data,
  input  logic [axi_mem_pkg::AXI_STRB_W-1:0] i_wr_strb,

  // Read port
  input  logic                              i_rd_en,
  input  logic [IDX_W-1:0]                  i_rd_idx,
  output logic [axi_mem_pkg::AXI_DATA_W-1:0] o_rd_data
);

  logic [axi_mem_pkg::AXI_DATA_W-1:0] mem [0:WORDS-1];

  // --------------------------------------------------------------------------
  // Byte lane writes

  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int lane = 0; lane < axi_mem_pkg::AXI_STRB_W; lane++) begin
        if (i_wr_strb[lane]) begin
          mem[i_wr_idx][lane*8 +: 8] <= i_wr_data[lane*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Registered read, held between enables
  // A read of the word being written returns the old contents

  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_idx];
    end
  end

  // --------------------------------------------------------------------------
  // Checks

  a_wr_idx_range : assert property (
    @(posedge i_aclk) i_wr_en |-> (i_wr_idx < WORDS)
  ) else $error("sram_array: write index %0d beyond %0d words", i_wr_idx, WORDS);

  a_rd_idx_range : assert property (
    @(posedge i_aclk) i_rd_en |-> (i_rd_idx < WORDS)
  ) else $error("sram_array: read index %0d beyond %0d words", i_rd_idx, WORDS);

endmodule

//--- project.f
+incdir+bench
design/axi_mem_pkg.sv
design/sram_array.sv
design/axi_sram_slave.sv
design/axi_mem_top.sv
bench/axi_mem_tb.sv
